// File: command_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no handshake. unknown opcodes are dropped, next byte is an opcode again.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "led_matrix_settings.svh"

module command_decoder (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       enable,
    input  wire logic [7:0] data_in,
    input  wire logic       readrow_done,
    input  wire logic       fillrow_done,
    output logic            readrow_enable,
    output logic            fillrow_enable,
    output logic            sel_fill,
    output logic            busy,
    output logic            cmd_done
);
    typedef enum logic [1:0] {
        ST_OPCODE,
        ST_READROW,
        ST_FILLROW
    } dec_state_t;

    dec_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_OPCODE;
        end else begin
            case (state)
                ST_OPCODE: begin
                    if (enable && data_in == `OP_READROW) begin
                        state <= ST_READROW;
                    end else if (enable && data_in == `OP_FILLROW) begin
                        state <= ST_FILLROW;
                    end
                end
                ST_READROW: if (readrow_done) state <= ST_OPCODE;
                ST_FILLROW: if (fillrow_done) state <= ST_OPCODE;
                default:    state <= ST_OPCODE;
            endcase
        end
    end

    // bytes only reach the handler that owns the command.
    assign readrow_enable = enable && (state == ST_READROW);
    assign fillrow_enable = enable && (state == ST_FILLROW);
    assign sel_fill       = (state == ST_FILLROW);
    assign busy           = (state != ST_OPCODE);

    assign cmd_done = (state == ST_READROW && readrow_done) ||
                      (state == ST_FILLROW && fillrow_done);

endmodule

`default_nettype wire

// File: control_cmd_fillrow.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour bytes come as 2, 1, 0. bytes during the 48-cycle sweep are ignored.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "led_matrix_settings.svh"

module control_cmd_fillrow (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic [7:0]     data_in,
    input  wire logic           enable,
    output led_matrix_pkg::ram_wr_t wr,
    output logic                done
);
    import led_matrix_pkg::*;

    localparam col_addr_t   LAST_COL  = col_addr_t'(`PIXEL_WIDTH - 1);
    localparam pixel_addr_t LAST_BYTE = pixel_addr_t'(`BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        ST_ROW_CAPTURE,
        ST_COLOUR,
        ST_SWEEP,
        ST_DONE
    } fillrow_state_t;

    fillrow_state_t state;
    pixel_addr_t    lane;     // next colour byte to capture.
    pixel_t         colour;

    always_ff @(posedge clk) begin
        if (state == ST_COLOUR && enable) colour[lane] <= data_in;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_ROW_CAPTURE;
            lane  <= '0;
            wr    <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                ST_ROW_CAPTURE: begin
                    if (enable) begin
                        wr.row <= row_addr_t'(data_in);
                        lane   <= LAST_BYTE;
                        state  <= ST_COLOUR;
                    end
                end

                ST_COLOUR: begin
                    if (enable) begin
                        lane <= lane - pixel_addr_t'(1);
                        if (lane == '0) begin          // last colour byte, start sweep.
                            wr.column       <= LAST_COL;
                            wr.pixel        <= LAST_BYTE;
                            wr.data         <= colour[LAST_BYTE];
                            wr.write_enable <= 1'b1;
                            wr.access_start <= ~wr.access_start;
                            state           <= ST_SWEEP;
                        end
                    end
                end

                //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
                // one lane per cycle, columns from the last down to 0.
                //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
                ST_SWEEP: begin
                    wr.access_start <= ~wr.access_start;
                    if (wr.pixel == '0) begin
                        wr.pixel  <= LAST_BYTE;
                        wr.column <= wr.column - col_addr_t'(1);
                        wr.data   <= colour[LAST_BYTE];
                    end else begin
                        wr.pixel <= wr.pixel - pixel_addr_t'(1);
                        wr.data  <= colour[wr.pixel - pixel_addr_t'(1)];
                        if (wr.column == '0 && wr.pixel == pixel_addr_t'(1)) begin
                            done  <= 1'b1;
                            state <= ST_DONE;
                        end
                    end
                end

                ST_DONE: begin
                    done            <= 1'b0;
                    wr.write_enable <= 1'b0;
                    state           <= ST_ROW_CAPTURE;
                end

                default: state <= ST_ROW_CAPTURE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: control_cmd_readrow.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// row byte, then exactly one row of data, last column and colour byte first.
// each byte reaches the RAM port one cycle after its enable cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "led_matrix_settings.svh"

module control_cmd_readrow (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic [7:0]     data_in,
    input  wire logic           enable,
    output led_matrix_pkg::ram_wr_t wr,
    output logic                done
);
    import led_matrix_pkg::*;

    localparam col_addr_t   LAST_COL  = col_addr_t'(`PIXEL_WIDTH - 1);
    localparam pixel_addr_t LAST_BYTE = pixel_addr_t'(`BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        ST_ROW_CAPTURE,
        ST_PRIME,
        ST_ROW_DATA,
        ST_DONE
    } readrow_state_t;

    readrow_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_ROW_CAPTURE;
            wr    <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                ST_ROW_CAPTURE: begin
                    if (enable) begin
                        wr.row <= row_addr_t'(data_in);
                        state  <= ST_PRIME;
                    end
                end

                // first data byte lands on the last column, top byte.
                ST_PRIME: begin
                    if (enable) begin
                        wr.column       <= LAST_COL;
                        wr.pixel        <= LAST_BYTE;
                        wr.data         <= data_in;
                        wr.write_enable <= 1'b1;
                        wr.access_start <= ~wr.access_start;
                        state           <= ST_ROW_DATA;
                    end
                end

                ST_ROW_DATA: begin
                    if (enable) begin
                        wr.data         <= data_in;
                        wr.access_start <= ~wr.access_start;
                        if (wr.pixel == '0) begin
                            wr.pixel  <= LAST_BYTE;       // next column down.
                            wr.column <= wr.column - col_addr_t'(1);
                        end else begin
                            wr.pixel <= wr.pixel - pixel_addr_t'(1);
                            if (wr.column == '0 && wr.pixel == pixel_addr_t'(1)) begin
                                done  <= 1'b1;            // column 0, byte 0.
                                state <= ST_DONE;
                            end
                        end
                    end
                end

                ST_DONE: begin
                    done            <= 1'b0;
                    wr.write_enable <= 1'b0;
                    state           <= ST_ROW_CAPTURE;
                end

                default: state <= ST_ROW_CAPTURE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: frame_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one byte lane written per strobe toggle. read data is one cycle late.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "led_matrix_settings.svh"

module frame_ram (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire led_matrix_pkg::ram_wr_t   wr,
    input  wire led_matrix_pkg::row_addr_t rd_row,
    input  wire led_matrix_pkg::col_addr_t rd_col,
    output led_matrix_pkg::pixel_t         rd_pixel
);
    import led_matrix_pkg::*;

    localparam int DEPTH = `PIXEL_WIDTH * `PIXEL_HEIGHT;

    pixel_t mem [DEPTH] = '{default: '0};   // frame powers up black.
    logic   prev_strobe;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_strobe <= 1'b0;
        end else begin
            prev_strobe <= wr.access_start;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.write_enable && (wr.access_start != prev_strobe)) begin
            mem[{wr.row, wr.column}][wr.pixel] <= wr.data;
        end
        rd_pixel <= mem[{rd_row, rd_col}];
    end

endmodule

`default_nettype wire

// File: led_matrix.f
+incdir+.
led_matrix_pkg.sv
command_decoder.sv
control_cmd_readrow.sv
control_cmd_fillrow.sv
frame_ram.sv
scan_out.sv
led_matrix_top.sv
led_matrix_props.sv
led_matrix_checker.sv
led_matrix_tb.sv

// File: led_matrix_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checks one frame from the first frame_start after check_en rises.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "led_matrix_settings.svh"

module led_matrix_checker (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      check_en,
    input  wire led_matrix_pkg::pixel_t [`PIXEL_WIDTH*`PIXEL_HEIGHT-1:0] exp_frame,
    input  wire led_matrix_pkg::row_addr_t row,
    input  wire led_matrix_pkg::col_addr_t column,
    input  wire led_matrix_pkg::pixel_t    pixel,
    input  wire logic                      pixel_valid,
    input  wire logic                      frame_start,
    output logic                           frame_checked,
    output int                             error_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import led_matrix_pkg::*;

    localparam int DEPTH = `PIXEL_WIDTH * `PIXEL_HEIGHT;

    logic active;
    int   count;   // pixels compared so far.

    task automatic compare_pixel(input int idx);
        int exp_row;
        int exp_col;
        exp_row = idx / `PIXEL_WIDTH;
        exp_col = idx % `PIXEL_WIDTH;
        if (int'(row) != exp_row || int'(column) != exp_col) begin
            error_count++;
            $display("Mismatch at %0t: scan at row %0d col %0d, expected row %0d col %0d",
                     $time, row, column, exp_row, exp_col);
        end else if (pixel !== exp_frame[idx]) begin
            error_count++;
            $display("Mismatch at %0t: row %0d col %0d expected %06h got %06h",
                     $time, row, column, exp_frame[idx], pixel);
        end
    endtask

    // outputs settle after the rising edge.
    always @(negedge clk) begin
        if (reset) begin
            error_count = 0;
            active        <= 1'b0;
            frame_checked <= 1'b0;
            count         <= 0;
        end else if (!check_en) begin
            active        <= 1'b0;
            frame_checked <= 1'b0;
            count         <= 0;
        end else if (pixel_valid && !frame_checked) begin
            if (!active) begin
                if (frame_start) begin
                    compare_pixel(0);
                    active <= 1'b1;
                    count  <= 1;
                end
            end else if (count == DEPTH) begin
                if (!frame_start) begin
                    error_count++;
                    $display("frame_start did not return after %0d pixels", DEPTH);
                end
                active        <= 1'b0;
                frame_checked <= 1'b1;
            end else begin
                if (frame_start) begin
                    error_count++;
                    $display("frame_start came early, at pixel %0d", count);
                end
                compare_pixel(count);
                count <= count + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: led_matrix_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address widths follow the geometry macros. byte 0 is the low colour byte.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "led_matrix_settings.svh"

package led_matrix_pkg;

    typedef logic [$clog2(`PIXEL_HEIGHT)-1:0]    row_addr_t;
    typedef logic [$clog2(`PIXEL_WIDTH)-1:0]     col_addr_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_addr_t;

    // one colour, byte 2 in the top lane.
    typedef logic [`BYTES_PER_PIXEL-1:0][7:0] pixel_t;

    // write request from a handler to the frame RAM.
    typedef struct packed {
        row_addr_t   row;
        col_addr_t   column;
        pixel_addr_t pixel;        // colour byte lane.
        logic [7:0]  data;
        logic        write_enable;
        logic        access_start; // toggles once per byte.
    } ram_wr_t;

endpackage

`default_nettype wire

// File: led_matrix_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound twice. ports that a target lacks are tied low.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module led_matrix_props (
    input wire logic                      clk,
    input wire logic                      reset,
    input wire logic                      readrow_enable,
    input wire logic                      fillrow_enable,
    input wire logic                      cmd_done,
    input wire logic                      frame_start,
    input wire led_matrix_pkg::row_addr_t row,
    input wire led_matrix_pkg::col_addr_t column
);
    timeunit 1ns;
    timeprecision 1ps;

    // only one handler sees bytes at a time.
    assert property (@(posedge clk) disable iff (reset) !(readrow_enable && fillrow_enable))
        else $error("both handlers enabled in the same cycle");

    // raster steps on from the frame's first pixel.
    assert property (@(posedge clk) disable iff (reset)
        frame_start |=> (row == '0 && column == 1))
        else $error("raster did not step to row 0, column 1 after frame_start");

    assert property (@(posedge clk) disable iff (reset) cmd_done |=> !cmd_done)
        else $error("cmd_done held for more than one cycle");

endmodule

bind command_decoder led_matrix_props decoder_props_i (
    .clk(clk), .reset(reset), .readrow_enable(readrow_enable),
    .fillrow_enable(fillrow_enable), .cmd_done(cmd_done),
    .frame_start(1'b0), .row('0), .column('0)
);

bind scan_out led_matrix_props scan_props_i (
    .clk(clk), .reset(reset), .readrow_enable(1'b0), .fillrow_enable(1'b0),
    .cmd_done(1'b0), .frame_start(frame_start), .row(row), .column(column)
);

`default_nettype wire

// File: led_matrix_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix geometry is fixed here. width and height must stay powers of two.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LED_MATRIX_SETTINGS_SVH
`define LED_MATRIX_SETTINGS_SVH

`define PIXEL_WIDTH     16      // columns per row.
`define PIXEL_HEIGHT    8       // rows.
`define BYTES_PER_PIXEL 3       // colour bytes per pixel.

// command opcodes.
`define OP_READROW      8'h01
`define OP_FILLROW      8'h02

`endif

// File: led_matrix_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed random seed. frames are compared in led_matrix_checker.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "led_matrix_settings.svh"

module led_matrix_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import led_matrix_pkg::*;

    localparam int DEPTH       = `PIXEL_WIDTH * `PIXEL_HEIGHT;
    localparam int ROW_BYTES   = `PIXEL_WIDTH * `BYTES_PER_PIXEL;
    localparam int CMD_TIMEOUT = 200;
    localparam int FRAME_WAIT  = 400;   // up to one frame to start, one to check.

    typedef logic [7:0] byte_list_t[$];
    typedef pixel_t [DEPTH-1:0] frame_t;

    logic       clk;
    logic       reset;
    logic       enable;
    logic [7:0] data_in;
    logic       cmd_done;
    logic       busy;
    row_addr_t  row;
    col_addr_t  column;
    pixel_t     pixel;
    logic       pixel_valid;
    logic       frame_start;
    logic       check_en;
    logic       frame_checked;
    int         check_errors;
    int         tb_errors;
    int         seed;
    frame_t     model;   // expected frame.

    led_matrix_top dut_i (
        .clk, .reset, .enable, .data_in, .cmd_done, .busy,
        .row, .column, .pixel, .pixel_valid, .frame_start
    );

    led_matrix_checker checker_i (
        .clk, .reset, .check_en, .exp_frame(model), .row, .column, .pixel,
        .pixel_valid, .frame_start, .frame_checked, .error_count(check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command building and reference model
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [7:0] random_byte();
        return 8'($random(seed));
    endfunction

    function automatic byte_list_t readrow_cmd(input int r);
        byte_list_t cmd;
        cmd.push_back(`OP_READROW);
        cmd.push_back(8'(r));
        repeat (ROW_BYTES) cmd.push_back(random_byte());
        return cmd;
    endfunction

    function automatic byte_list_t fillrow_cmd(input int r);
        byte_list_t cmd;
        cmd.push_back(`OP_FILLROW);
        cmd.push_back(8'(r));
        repeat (`BYTES_PER_PIXEL) cmd.push_back(random_byte());   // byte 2 first.
        return cmd;
    endfunction

    function automatic frame_t apply_command(input frame_t frame, input byte_list_t cmd);
        frame_t next;
        int     r;
        int     col;
        int     lane;
        int     k;
        next = frame;
        if (cmd.size() < 2) return next;
        r = int'(cmd[1]) % `PIXEL_HEIGHT;
        if (cmd[0] == `OP_READROW) begin
            // last column first, top colour byte first within a column.
            for (k = 0; k < ROW_BYTES && k + 2 < cmd.size(); k++) begin
                col  = `PIXEL_WIDTH - 1 - k / `BYTES_PER_PIXEL;
                lane = `BYTES_PER_PIXEL - 1 - k % `BYTES_PER_PIXEL;
                next[r * `PIXEL_WIDTH + col][lane] = cmd[k + 2];
            end
        end else if (cmd[0] == `OP_FILLROW && cmd.size() >= 2 + `BYTES_PER_PIXEL) begin
            for (col = 0; col < `PIXEL_WIDTH; col++) begin
                for (lane = 0; lane < `BYTES_PER_PIXEL; lane++) begin
                    next[r * `PIXEL_WIDTH + col][lane] = cmd[1 + `BYTES_PER_PIXEL - lane];
                end
            end
        end
        return next;
    endfunction

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_bytes(input byte_list_t cmd);
        foreach (cmd[i]) begin
            @(posedge clk);
            enable  <= 1'b1;
            data_in <= cmd[i];
        end
        @(posedge clk);
        enable  <= 1'b0;
        data_in <= 8'h00;
    endtask

    task automatic wait_cmd_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cmd_done && cycles < CMD_TIMEOUT);
        if (!cmd_done) begin
            tb_errors++;
            $display("no cmd_done within %0d cycles of the last byte", CMD_TIMEOUT);
        end
    endtask

    task automatic run_command(input byte_list_t cmd);
        send_bytes(cmd);
        wait_cmd_done();
        model = apply_command(model, cmd);
    endtask

    // a dropped opcode must leave the decoder idle.
    task automatic watch_idle(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (cmd_done || busy) begin
                tb_errors++;
                $display("decoder reacted to an unknown opcode at %0t", $time);
            end
        end
    endtask

    task automatic check_frame(input string what);
        int cycles;
        repeat (2) @(posedge clk);   // last RAM write has landed.
        check_en <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!frame_checked && cycles < FRAME_WAIT);
        if (!frame_checked) begin
            tb_errors++;
            $display("%s: no complete frame seen within %0d cycles", what, FRAME_WAIT);
        end
        @(posedge clk);
        check_en <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        byte_list_t cmd;
        int         r;
        seed      = 34;
        tb_errors = 0;
        model     = '0;
        reset     = 1'b1;
        enable    = 1'b0;
        data_in   = 8'h00;
        check_en  = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (cmd_done || busy || pixel_valid || frame_start) begin
            tb_errors++;
            $display("cmd_done, busy, pixel_valid or frame_start high right after reset");
        end
        check_frame("blank frame after reset");

        run_command(readrow_cmd(3));
        check_frame("read row 3");
        run_command(fillrow_cmd(7));
        check_frame("fill row 7");
        run_command(readrow_cmd(5));
        run_command(fillrow_cmd(5));
        check_frame("fill over read row 5");

        cmd.push_back(8'h7e);
        send_bytes(cmd);
        watch_idle(8);
        run_command(readrow_cmd(1));
        check_frame("unknown opcode, then read row 1");

        for (r = 0; r < `PIXEL_HEIGHT; r++) begin
            if (r % 2 == 0) run_command(readrow_cmd(r));
            else run_command(fillrow_cmd(r));
        end
        check_frame("all rows back to back");

        @(posedge clk);
        $display("errors: %0d in testbench, %0d in frame checker", tb_errors, check_errors);
        if (tb_errors + check_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: led_matrix_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-only command port. host waits for cmd_done before the next opcode.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module led_matrix_top (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 enable,
    input  wire logic [7:0]           data_in,
    output logic                      cmd_done,
    output logic                      busy,
    output led_matrix_pkg::row_addr_t row,
    output led_matrix_pkg::col_addr_t column,
    output led_matrix_pkg::pixel_t    pixel,
    output logic                      pixel_valid,
    output logic                      frame_start
);
    import led_matrix_pkg::*;

    logic      readrow_enable;
    logic      fillrow_enable;
    logic      readrow_done;
    logic      fillrow_done;
    logic      sel_fill;
    ram_wr_t   readrow_wr;
    ram_wr_t   fillrow_wr;
    ram_wr_t   ram_wr;
    row_addr_t rd_row;
    col_addr_t rd_col;
    pixel_t    rd_pixel;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command side
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    command_decoder decoder_i (
        .clk, .reset, .enable, .data_in, .readrow_done, .fillrow_done,
        .readrow_enable, .fillrow_enable, .sel_fill, .busy, .cmd_done
    );

    control_cmd_readrow readrow_i (
        .clk, .reset, .data_in, .enable(readrow_enable), .wr(readrow_wr), .done(readrow_done)
    );

    control_cmd_fillrow fillrow_i (
        .clk, .reset, .data_in, .enable(fillrow_enable), .wr(fillrow_wr), .done(fillrow_done)
    );

    assign ram_wr = sel_fill ? fillrow_wr : readrow_wr;   // active handler owns the port.

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame store and scan
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    frame_ram ram_i (
        .clk, .reset, .wr(ram_wr), .rd_row, .rd_col, .rd_pixel
    );

    scan_out scan_i (
        .clk, .reset, .rd_row, .rd_col, .rd_pixel,
        .row, .column, .pixel, .pixel_valid, .frame_start
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the LED matrix testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module led_matrix_tb -f led_matrix.f -o led_matrix_sim

./obj_dir/led_matrix_sim | tee sim.log

# exit status follows the search.
grep -qx '>>> PASS' sim.log

// File: scan_out.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free-running raster, one pixel per cycle. first pixel two cycles after reset.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "led_matrix_settings.svh"

module scan_out (
    input  wire logic                   clk,
    input  wire logic                   reset,
    output led_matrix_pkg::row_addr_t   rd_row,
    output led_matrix_pkg::col_addr_t   rd_col,
    input  wire led_matrix_pkg::pixel_t rd_pixel,
    output led_matrix_pkg::row_addr_t   row,
    output led_matrix_pkg::col_addr_t   column,
    output led_matrix_pkg::pixel_t      pixel,
    output logic                        pixel_valid,
    output logic                        frame_start
);
    import led_matrix_pkg::*;

    localparam row_addr_t LAST_ROW = row_addr_t'(`PIXEL_HEIGHT - 1);
    localparam col_addr_t LAST_COL = col_addr_t'(`PIXEL_WIDTH - 1);

    logic run;   // counters hold for one cycle after reset.

    always_ff @(posedge clk) begin
        if (reset) begin
            run         <= 1'b0;
            rd_row      <= '0;
            rd_col      <= '0;
            row         <= '0;
            column      <= '0;
            pixel_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (run) begin
                rd_col <= (rd_col == LAST_COL) ? '0 : rd_col + col_addr_t'(1);
                if (rd_col == LAST_COL) begin
                    rd_row <= (rd_row == LAST_ROW) ? '0 : rd_row + row_addr_t'(1);
                end
            end
            // aligned with the RAM read latency.
            row         <= rd_row;
            column      <= rd_col;
            pixel_valid <= run;
        end
    end

    assign pixel       = rd_pixel;
    assign frame_start = pixel_valid && (row == '0) && (column == '0);

endmodule

`default_nettype wire
